//--- logic/fetch_pkg.sv
package fetch_pkg;

	// Byte address width of the fetch path and the instruction bus.
	localparam int unsigned ADDR_W = 32;

	// Request from the sequencer to the cache.
	typedef struct packed {
		logic [ADDR_W-1:0] pc;
	} fetch_req_t;

	// Fetched instruction together with the address it came from.
	typedef struct packed {
		logic [ADDR_W-1:0] pc;
		logic [31:0] instr;
	} fetch_rsp_t;

	// Wishbone classic master outputs.
	// The address is a byte address.
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [ADDR_W-1:0] adr;
	} wb_m2s_t;

	// Wishbone classic slave outputs.
	typedef struct packed {
		logic ack;
		logic [31:0] dat;
	} wb_s2m_t;

endpackage

//--- logic/line_ram.sv
module line_ram #(
	parameter int WIDTH = 32,
	parameter int DEPTH_LOG2 = 3
)(
	input logic i_clock,
	input logic i_write,
	input logic [DEPTH_LOG2-1:0] i_address,
	input logic [WIDTH-1:0] i_wdata,
	output logic [WIDTH-1:0] o_rdata
);

	localparam int DEPTH = 1 << DEPTH_LOG2;

	logic [WIDTH-1:0] mem [DEPTH];

	// Registered read, so the data follows the address by one cycle.
	// A write returns the old contents on the same edge.
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			mem[i_address] <= i_wdata;
		end
		o_rdata <= mem[i_address];
	end

endmodule

//--- logic/fetch_sequencer.sv
module fetch_sequencer import fetch_pkg::*; #(
	parameter logic [ADDR_W-1:0] RESET_PC = '0
)(
	input logic i_clock,
	input logic i_reset,

	input logic i_redirect_valid,
	input logic [ADDR_W-1:0] i_redirect_pc,

	output logic o_req_valid,
	output fetch_req_t o_req,
	input logic i_req_ready,

	input logic i_rsp_valid,
	input fetch_rsp_t i_rsp,
	output logic o_rsp_ready,

	output logic o_out_valid,
	output fetch_rsp_t o_out,
	input logic i_out_ready
);

	typedef enum logic [1:0] {
		seq_launch,
		seq_request,
		seq_wait
	} seq_state_t;

	seq_state_t state;
	logic [ADDR_W-1:0] pc_q;
	logic [ADDR_W-1:0] redirect_pc_q;
	logic kill_q;
	logic out_valid_q;
	fetch_rsp_t out_q;
	logic rsp_fire;

	assign o_req_valid = (state == seq_request);
	assign o_req.pc = pc_q;

	// A killed response is taken even while the output is stalled.
	assign o_rsp_ready = kill_q || i_out_ready;
	assign rsp_fire = i_rsp_valid && o_rsp_ready;

	assign o_out_valid = out_valid_q;
	assign o_out = out_q;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= seq_launch;
			pc_q <= RESET_PC;
			kill_q <= 1'b0;
			out_valid_q <= 1'b0;
		end else begin
			if (out_valid_q && i_out_ready) begin
				out_valid_q <= 1'b0;
			end

			// A request is in flight or waiting, so the redirect applies to the next one.
			if (i_redirect_valid && state != seq_launch) begin
				kill_q <= 1'b1;
				redirect_pc_q <= i_redirect_pc;
			end

			case (state)
				seq_launch: begin
					state <= seq_request;
					if (i_redirect_valid) begin
						pc_q <= i_redirect_pc;
					end
				end
				seq_request: begin
					if (i_req_ready) begin
						state <= seq_wait;
					end
				end
				seq_wait: begin
					if (rsp_fire) begin
						state <= seq_request;
						kill_q <= 1'b0;
						if (i_redirect_valid) begin
							pc_q <= i_redirect_pc;
						end else if (kill_q) begin
							pc_q <= redirect_pc_q;
						end else begin
							pc_q <= pc_q + ADDR_W'(4);
							out_q <= i_rsp;
							out_valid_q <= 1'b1;
						end
					end
				end
				default: state <= seq_launch;
			endcase
		end
	end

endmodule

//--- logic/icache.sv
module icache import fetch_pkg::*; #(
	parameter int INDEX_BITS = 3
)(
	input logic i_clock,
	input logic i_reset,

	input logic i_req_valid,
	input fetch_req_t i_req,
	output logic o_req_ready,

	output logic o_rsp_valid,
	output fetch_rsp_t o_rsp,
	input logic i_rsp_ready,

	output wb_m2s_t o_wb,
	input wb_s2m_t i_wb
);

	localparam int TAG_W = ADDR_W - INDEX_BITS - 2;

	typedef struct packed {
		logic valid;
		logic [TAG_W-1:0] tag;
		logic [31:0] data;
	} line_t;

	typedef enum logic [2:0] {
		st_clear,
		st_idle,
		st_lookup,
		st_bus,
		st_respond
	} cache_state_t;

	cache_state_t state;
	logic [INDEX_BITS-1:0] clear_index;
	logic read_pending;
	logic bus_q;
	logic rsp_valid_q;
	logic [ADDR_W-1:0] pc_q;
	logic [31:0] instr_q;

	logic [INDEX_BITS-1:0] pc_index;
	logic [TAG_W-1:0] pc_tag;
	logic hit;

	logic ram_write;
	logic [INDEX_BITS-1:0] ram_address;
	line_t ram_wdata;
	line_t rd_line;

	assign pc_index = pc_q[INDEX_BITS+1:2];
	assign pc_tag = pc_q[ADDR_W-1 -: TAG_W];
	assign hit = rd_line.valid && (rd_line.tag == pc_tag);

	// Clearing owns the memory, otherwise it follows the latched pc.
	always_comb begin
		ram_write = 1'b0;
		ram_address = pc_index;
		ram_wdata = '{valid: 1'b1, tag: pc_tag, data: i_wb.dat};
		if (state == st_clear) begin
			ram_write = 1'b1;
			ram_address = clear_index;
			ram_wdata = '0;
		end else if (state == st_bus && i_wb.ack) begin
			ram_write = 1'b1;
		end
	end

	line_ram #(
		.WIDTH($bits(line_t)),
		.DEPTH_LOG2(INDEX_BITS)
	) lines (
		.i_clock(i_clock),
		.i_write(ram_write),
		.i_address(ram_address),
		.i_wdata(ram_wdata),
		.o_rdata(rd_line)
	);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= st_clear;
			clear_index <= '0;
			read_pending <= 1'b0;
			bus_q <= 1'b0;
			rsp_valid_q <= 1'b0;
		end else begin
			case (state)
				st_clear: begin
					clear_index <= clear_index + 1'b1;
					if (clear_index == '1) begin
						state <= st_idle;
					end
				end
				st_idle: begin
					if (i_req_valid) begin
						read_pending <= 1'b1;
						state <= st_lookup;
					end
				end
				st_lookup: begin
					// First cycle waits for the registered line read.
					if (read_pending) begin
						read_pending <= 1'b0;
					end else if (hit) begin
						rsp_valid_q <= 1'b1;
						state <= st_respond;
					end else begin
						bus_q <= 1'b1;
						state <= st_bus;
					end
				end
				st_bus: begin
					if (i_wb.ack) begin
						bus_q <= 1'b0;
						rsp_valid_q <= 1'b1;
						state <= st_respond;
					end
				end
				st_respond: begin
					if (i_rsp_ready) begin
						rsp_valid_q <= 1'b0;
						state <= st_idle;
					end
				end
				default: state <= st_clear;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == st_idle && i_req_valid) begin
			pc_q <= i_req.pc;
		end
		if (state == st_lookup && !read_pending) begin
			instr_q <= rd_line.data;
		end
		if (state == st_bus && i_wb.ack) begin
			instr_q <= i_wb.dat;
		end
	end

	assign o_req_ready = (state == st_idle);
	assign o_rsp_valid = rsp_valid_q;
	assign o_rsp.pc = pc_q;
	assign o_rsp.instr = instr_q;

	assign o_wb.cyc = bus_q;
	assign o_wb.stb = bus_q;
	assign o_wb.we = 1'b0;
	assign o_wb.adr = {pc_q[ADDR_W-1:2], 2'b00};

	a_stb_needs_cyc: assert property (@(posedge i_clock) disable iff (i_reset)
		o_wb.stb |-> o_wb.cyc);

	// The slave may take its time, the address must wait with it.
	a_adr_hold: assert property (@(posedge i_clock) disable iff (i_reset)
		o_wb.stb && !i_wb.ack |=> o_wb.stb && $stable(o_wb.adr));

	a_rsp_hold: assert property (@(posedge i_clock) disable iff (i_reset)
		o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp));

endmodule

//--- logic/instruction_rom.sv
module instruction_rom import fetch_pkg::*; #(
	parameter int ROM_WORDS_LOG2 = 5,
	parameter int WAIT_STATES = 2
)(
	input logic i_clock,
	input logic i_reset,
	input wb_m2s_t i_wb,
	output wb_s2m_t o_wb
);

	localparam int DEPTH = 1 << ROM_WORDS_LOG2;
	localparam int COUNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

	logic [31:0] mem [DEPTH];
	logic [COUNT_W-1:0] wait_count;
	logic ack_q;
	logic [31:0] dat_q;
	logic bus_active;
	logic done;

	initial begin
		$readmemh("program.hex", mem);
	end

	// A cycle that was just acked is not counted again.
	assign bus_active = i_wb.cyc && i_wb.stb && !ack_q;
	assign done = bus_active && (wait_count == COUNT_W'(WAIT_STATES));

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			ack_q <= 1'b0;
			wait_count <= '0;
		end else begin
			ack_q <= done;
			if (bus_active && !done) begin
				wait_count <= wait_count + 1'b1;
			end else begin
				wait_count <= '0;
			end
		end
	end

	// Word address wraps at the ROM depth.
	always_ff @(posedge i_clock) begin
		if (done) begin
			dat_q <= mem[i_wb.adr[ROM_WORDS_LOG2+1:2]];
		end
	end

	assign o_wb.ack = ack_q;
	assign o_wb.dat = dat_q;

	a_ack_needs_stb: assert property (@(posedge i_clock) disable iff (i_reset)
		o_wb.ack |-> i_wb.cyc && i_wb.stb);

endmodule

//--- logic/fetch_top.sv
module fetch_top import fetch_pkg::*; #(
	parameter int INDEX_BITS = 3,
	parameter int ROM_WORDS_LOG2 = 5,
	parameter int WAIT_STATES = 2,
	parameter logic [ADDR_W-1:0] RESET_PC = '0
)(
	input logic i_clock,
	input logic i_reset,

	input logic i_redirect_valid,
	input logic [ADDR_W-1:0] i_redirect_pc,

	output logic o_out_valid,
	output fetch_rsp_t o_out,
	input logic i_out_ready
);

	logic req_valid;
	logic req_ready;
	fetch_req_t req;
	logic rsp_valid;
	logic rsp_ready;
	fetch_rsp_t rsp;
	wb_m2s_t wb_m2s;
	wb_s2m_t wb_s2m;

	fetch_sequencer #(
		.RESET_PC(RESET_PC)
	) sequencer (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_redirect_valid(i_redirect_valid),
		.i_redirect_pc(i_redirect_pc),
		.o_req_valid(req_valid),
		.o_req(req),
		.i_req_ready(req_ready),
		.i_rsp_valid(rsp_valid),
		.i_rsp(rsp),
		.o_rsp_ready(rsp_ready),
		.o_out_valid(o_out_valid),
		.o_out(o_out),
		.i_out_ready(i_out_ready)
	);

	icache #(
		.INDEX_BITS(INDEX_BITS)
	) cache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_req_valid(req_valid),
		.i_req(req),
		.o_req_ready(req_ready),
		.o_rsp_valid(rsp_valid),
		.o_rsp(rsp),
		.i_rsp_ready(rsp_ready),
		.o_wb(wb_m2s),
		.i_wb(wb_s2m)
	);

	instruction_rom #(
		.ROM_WORDS_LOG2(ROM_WORDS_LOG2),
		.WAIT_STATES(WAIT_STATES)
	) rom (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_wb(wb_m2s),
		.o_wb(wb_s2m)
	);

endmodule

//--- test/tb_clock.sv
module tb_clock #(
	parameter int PERIOD = 20
)(
	output logic o_clock
);

	// Free running clock, low for the first half period.
	initial begin
		o_clock = 1'b0;
	end

	always begin
		#(PERIOD / 2);
		o_clock = ~o_clock;
	end

endmodule

//--- test/fetch_top_tb.sv
module fetch_top_tb import fetch_pkg::*; ();

	localparam int INDEX_BITS = 3;
	localparam int ROM_WORDS_LOG2 = 5;
	localparam int WAIT_STATES = 2;
	localparam logic [ADDR_W-1:0] RESET_PC = '0;
	localparam int CLEAR_CYCLES = 1 << INDEX_BITS;
	localparam int TAG_W = ADDR_W - INDEX_BITS - 2;
	localparam int MISS_GAP = 4 + WAIT_STATES + 2;
	// Back-pressure fetches count twice and each redirect adds its dropped fetch and its delay.
	localparam int FETCH_BUDGET = 16 + 13 + 2 * 40 + 6 * 7 + 10 + 6;
	localparam int WATCHDOG_TIME = FETCH_BUDGET * (8 + WAIT_STATES) * 20
		+ 2 * (3 + CLEAR_CYCLES) * 20;

	logic clock;
	logic reset;
	logic redirect_valid;
	logic [ADDR_W-1:0] redirect_pc;
	logic out_ready;
	logic out_valid;
	fetch_rsp_t out_word;

	// Reference model of the ROM and of the cache tags.
	logic [31:0] model [1 << ROM_WORDS_LOG2];
	logic [TAG_W-1:0] line_tag [CLEAR_CYCLES];
	logic [CLEAR_CYCLES-1:0] line_valid;
	logic [ADDR_W-1:0] exp_pc;
	logic [ADDR_W-1:0] dead_pc;
	logic dead_armed;
	logic gap_valid;
	int unsigned since_fire;
	int unsigned since_reset;
	int unsigned fire_count = 0;
	int unsigned hit_gaps = 0;
	int unsigned stall_count = 0;
	fetch_rsp_t held_out;
	string test_name;

	wire fire = out_valid && out_ready;
	wire [INDEX_BITS-1:0] out_index = out_word.pc[INDEX_BITS+1:2];
	wire predict_hit = line_valid[out_index]
		&& (line_tag[out_index] == out_word.pc[ADDR_W-1 -: TAG_W]);
	wire [31:0] expected_instr = model[out_word.pc[ROM_WORDS_LOG2+1:2]];

	tb_clock #(.PERIOD(20)) clock_gen (.o_clock(clock));

	fetch_top #(
		.INDEX_BITS(INDEX_BITS),
		.ROM_WORDS_LOG2(ROM_WORDS_LOG2),
		.WAIT_STATES(WAIT_STATES),
		.RESET_PC(RESET_PC)
	) uut (
		.i_clock(clock),
		.i_reset(reset),
		.i_redirect_valid(redirect_valid),
		.i_redirect_pc(redirect_pc),
		.o_out_valid(out_valid),
		.o_out(out_word),
		.i_out_ready(out_ready)
	);

	task automatic stop_run();
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic report_mismatch(input string check, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("[FAIL] %s, %s: expected %h, actual %h", test_name, check, expected, actual);
		stop_run();
	endtask

	task automatic report_problem(input string what);
		$display("Error in %s: %s.", test_name, what);
		stop_run();
	endtask

	// Tracks the expected pc and the lines that the cache should hold.
	always @(posedge clock) begin
		logic [ADDR_W-1:0] lost_pc;
		lost_pc = fire ? exp_pc + 4 : exp_pc;
		if (reset) begin
			exp_pc <= RESET_PC;
			line_valid <= '0;
			dead_armed <= 1'b0;
			gap_valid <= 1'b0;
			since_fire <= 0;
			since_reset <= 0;
		end else begin
			since_reset <= since_reset + 1;
			since_fire <= fire ? 1 : since_fire + 1;
			if (fire) begin
				fire_count <= fire_count + 1;
				exp_pc <= exp_pc + 4;
				line_valid[out_index] <= 1'b1;
				line_tag[out_index] <= out_word.pc[ADDR_W-1 -: TAG_W];
				dead_armed <= 1'b0;
				gap_valid <= 1'b1;
				if (gap_valid && predict_hit) begin
					hit_gaps <= hit_gaps + 1;
				end
			end
			if (!out_ready) begin
				gap_valid <= 1'b0;
				if (out_valid) begin
					stall_count <= stall_count + 1;
				end
			end
			// The outstanding fetch still goes through the cache before it is dropped.
			if (redirect_valid) begin
				dead_pc <= lost_pc;
				line_valid[lost_pc[INDEX_BITS+1:2]] <= 1'b1;
				line_tag[lost_pc[INDEX_BITS+1:2]] <= lost_pc[ADDR_W-1 -: TAG_W];
				exp_pc <= redirect_pc;
				dead_armed <= 1'b1;
				gap_valid <= 1'b0;
			end
		end
		held_out <= out_word;
	end

	a_quiet: assert property (@(posedge clock)
		reset || since_reset < CLEAR_CYCLES |=> !out_valid)
		else report_problem("output valid during reset or line clearing");

	a_pc: assert property (@(posedge clock) disable iff (reset)
		fire |-> out_word.pc == exp_pc)
		else report_mismatch("pc order", $sampled(exp_pc), $sampled(out_word.pc));

	a_instr: assert property (@(posedge clock) disable iff (reset)
		fire |-> out_word.instr == expected_instr)
		else report_mismatch("instr", $sampled(expected_instr), $sampled(out_word.instr));

	a_dropped: assert property (@(posedge clock) disable iff (reset)
		fire && dead_armed |-> out_word.pc != dead_pc)
		else report_problem("the fetch outstanding at the redirect reached the output");

	a_hit_gap: assert property (@(posedge clock) disable iff (reset)
		fire && gap_valid && predict_hit |-> since_fire == 4)
		else report_mismatch("hit gap", 4, $sampled(since_fire));

	a_miss_gap: assert property (@(posedge clock) disable iff (reset)
		fire && gap_valid && !predict_hit |-> since_fire >= MISS_GAP)
		else report_mismatch("miss gap", MISS_GAP, $sampled(since_fire));

	a_valid_held: assert property (@(posedge clock) disable iff (reset)
		out_valid && !out_ready |=> out_valid)
		else report_problem("output valid dropped while the output was stalled");

	a_out_held: assert property (@(posedge clock) disable iff (reset)
		out_valid && !out_ready |=> out_word == held_out)
		else report_mismatch("stalled output", $sampled(held_out), $sampled(out_word));

	task automatic apply_reset();
		reset = 1'b1;
		repeat (3) @(negedge clock);
		reset = 1'b0;
	endtask

	task automatic wait_outputs(input int unsigned count);
		int unsigned target;
		target = fire_count + count;
		while (fire_count < target) begin
			@(negedge clock);
		end
	endtask

	// Called on a falling edge, so the pulse covers exactly one rising edge.
	task automatic pulse_redirect(input logic [ADDR_W-1:0] pc);
		redirect_valid = 1'b1;
		redirect_pc = pc;
		@(negedge clock);
		redirect_valid = 1'b0;
	endtask

	task automatic stall_randomly(input int unsigned count);
		int unsigned target;
		target = fire_count + count;
		while (fire_count < target) begin
			@(negedge clock);
			out_ready = ($urandom % 4) != 0;
		end
		@(negedge clock);
		out_ready = 1'b1;
	endtask

	initial begin
		#(WATCHDOG_TIME);
		report_problem("the watchdog time ran out before the tests finished");
	end

	initial begin
		logic [ADDR_W-1:0] target_pc;
		void'($urandom(32'h88c1));
		$readmemh("program.hex", model);
		redirect_valid = 1'b0;
		redirect_pc = '0;
		out_ready = 1'b1;
		test_name = "reset_sequence";
		apply_reset();
		test_name = "cold_pass";
		wait_outputs(16);
		test_name = "warm_hits";
		pulse_redirect(32'h20);
		wait_outputs(12);
		test_name = "back_pressure";
		stall_randomly(40);
		test_name = "redirect";
		repeat (6) begin
			repeat ($urandom % 12) @(negedge clock);
			target_pc = ($urandom % 128) * 4;
			if (target_pc == exp_pc || target_pc == exp_pc + 4) begin
				target_pc = target_pc + 32'h40;
			end
			pulse_redirect(target_pc);
			wait_outputs(5);
		end
		test_name = "reset_reclear";
		// Every line holds the reset range, so a line kept over reset would hit.
		pulse_redirect(RESET_PC);
		wait_outputs(8);
		apply_reset();
		wait_outputs(6);
		if (hit_gaps > 0 && stall_count > 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			report_problem("the stimulus never reached a timed hit or a stalled output");
		end
	end

endmodule

//--- program.hex
// One 32-bit instruction word per line in hex, word addresses 0 to 31 in order.
00000013
00100093
00200113
00308193
00410213
00518293
00620313
00728393
00830413
00938493
00a40513
00b48593
00c50613
00d58693
00e60713
00f68793
01070813
01178893
01280913
01388993
01490a13
01598a93
016a0b13
017a8b93
018b0c13
019b8c93
01ac0d13
01bc8d93
01cd0e13
01dd8e93
01ee0f13
01fe8f93

//--- src.f
logic/fetch_pkg.sv
logic/line_ram.sv
logic/fetch_sequencer.sv
logic/icache.sv
logic/instruction_rom.sv
logic/fetch_top.sv
test/tb_clock.sv
test/fetch_top_tb.sv

//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - logic/fetch_pkg.sv
  - logic/line_ram.sv
  - logic/fetch_sequencer.sv
  - logic/icache.sv
  - logic/instruction_rom.sv
  - logic/fetch_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/fetch_top_tb.sv
